// File: source/display_config.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Display pixel path configuration.
// Frame geometry, tile size, FIFO depth and APB register map.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef DISPLAY_CONFIG_SVH
`define DISPLAY_CONFIG_SVH

// Frame geometry in pixels.
`define DISPLAY_FRAME_WIDTH      16
`define DISPLAY_FRAME_HEIGHT     8
`define DISPLAY_TILE_SHIFT       2    // Tile edge is 4 pixels.

`define DISPLAY_FIFO_DEPTH       8    // Must be a power of two.
`define DISPLAY_APB_ADDR_WIDTH   8

// Register map, byte addresses.
`define DISPLAY_REG_CTRL         8'h00
`define DISPLAY_REG_STATUS       8'h04
`define DISPLAY_REG_PALETTE_BASE 8'h40 // 16 words up to 0x7C.

`endif

// File: source/display_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Display pixel path package.
// Stream and palette-write types, state and register enums and the
// default 16-entry YUV palette.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package display_pkg;

    // Palette index with raster markers.
    typedef struct packed {
        logic [3:0] index;
        logic       line_end;
        logic       frame_end;
    } index_pixel_t;

    // Color is Y[9:6], U[5:3], V[2:0].
    typedef struct packed {
        logic [9:0] color;
        logic       line_end;
        logic       frame_end;
    } yuv_pixel_t;

    typedef struct packed {
        logic       enable;
        logic [3:0] index;
        logic [9:0] value;
    } palette_write_t;

    typedef enum logic {SCAN_IDLE, SCAN_ACTIVE} scan_state_t;

    typedef enum logic [1:0] {REG_NONE, REG_CTRL, REG_STATUS, REG_PALETTE} reg_select_t;

    // Sixteen color palette in YUV 4:3:3.
    localparam logic [9:0] YUV_VOID   = 10'b0000_100_100;
    localparam logic [9:0] WHITE      = 10'b1111_100_100;
    localparam logic [9:0] GREY       = 10'b1001_100_100;
    localparam logic [9:0] RED        = 10'b0101_011_110;
    localparam logic [9:0] PINK       = 10'b1001_011_101;
    localparam logic [9:0] DARKBROWN  = 10'b0011_011_100;
    localparam logic [9:0] BROWN      = 10'b0110_010_101;
    localparam logic [9:0] ORANGE     = 10'b1001_010_101;
    localparam logic [9:0] YELLOW     = 10'b1101_010_100;
    localparam logic [9:0] DARKGREEN  = 10'b0100_100_011;
    localparam logic [9:0] GREEN      = 10'b0110_010_011;
    localparam logic [9:0] LIGHTGREEN = 10'b1010_001_011;
    localparam logic [9:0] NIGHTBLUE  = 10'b0010_100_011;
    localparam logic [9:0] SEABLUE    = 10'b0100_101_010;
    localparam logic [9:0] SKYBLUE    = 10'b1000_101_010;
    localparam logic [9:0] CLOUDBLUE  = 10'b1101_100_011;

    // Entry 15 first, so DEFAULT_PALETTE[i] is entry i.
    localparam logic [15:0][9:0] DEFAULT_PALETTE = {
        CLOUDBLUE, SKYBLUE, SEABLUE, NIGHTBLUE, LIGHTGREEN, GREEN, DARKGREEN, YELLOW,
        ORANGE, BROWN, DARKBROWN, PINK, RED, GREY, WHITE, YUV_VOID
    };

endpackage

// File: source/display_apb_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Display APB register block.
// CTRL holds scan enable and index offset, STATUS reports FIFO level
// and a frame counter, and a 16-word window reaches the palette.
// Zero wait states on every transfer.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "display_config.svh"

module display_apb_regs (
    input  logic                                clock_in,
    input  logic                                reset_n_in,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [`DISPLAY_APB_ADDR_WIDTH-1:0]  paddr,
    input  logic [31:0]                         pwdata,
    output logic [31:0]                         prdata,
    output logic                                pready,
    input  logic [$clog2(`DISPLAY_FIFO_DEPTH):0] fifo_level,
    input  logic                                frame_done,
    output logic                                scan_enable,
    output logic [3:0]                          index_offset,
    output display_pkg::palette_write_t         palette_write,
    output logic [3:0]                          palette_read_index,
    input  logic [9:0]                          palette_read_color
);

    localparam logic [`DISPLAY_APB_ADDR_WIDTH-1:0] PALETTE_BASE = `DISPLAY_REG_PALETTE_BASE;
    localparam logic [`DISPLAY_APB_ADDR_WIDTH-1:0] PALETTE_SPAN = 64; // 16 words.

    display_pkg::reg_select_t reg_sel;
    logic                     apb_write;
    logic [7:0]               frame_count;
    logic [`DISPLAY_APB_ADDR_WIDTH-1:0] palette_offset;

    assign palette_offset = paddr - PALETTE_BASE;

    // Address decode.
    always_comb begin
        if (paddr == `DISPLAY_REG_CTRL) begin
            reg_sel = display_pkg::REG_CTRL;
        end else if (paddr == `DISPLAY_REG_STATUS) begin
            reg_sel = display_pkg::REG_STATUS;
        end else if (paddr >= PALETTE_BASE && paddr < PALETTE_BASE + PALETTE_SPAN &&
                     paddr[1:0] == 2'b00) begin
            reg_sel = display_pkg::REG_PALETTE;
        end else begin
            reg_sel = display_pkg::REG_NONE;
        end
    end

    assign pready    = psel & penable;          // Never stretches the access phase.
    assign apb_write = psel & penable & pwrite;

    // Word index inside the palette window, shared by write and readback.
    assign palette_read_index = palette_offset[5:2];

    // Palette write lasts exactly the access phase.
    always_comb begin
        palette_write.enable = apb_write && (reg_sel == display_pkg::REG_PALETTE);
        palette_write.index  = palette_read_index;
        palette_write.value  = pwdata[9:0];
    end

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            scan_enable  <= 1'b0;
            index_offset <= 4'd0;
            frame_count  <= 8'd0;
        end else begin
            if (apb_write && reg_sel == display_pkg::REG_CTRL) begin
                scan_enable  <= pwdata[0];
                index_offset <= pwdata[7:4];
            end
            if (frame_done) frame_count <= frame_count + 8'd1; // Wraps at 256.
        end
    end

    // Read mux.
    always_comb begin
        prdata = 32'd0;
        if (psel) begin
            case (reg_sel)
                display_pkg::REG_CTRL:    prdata = {24'd0, index_offset, 3'd0, scan_enable};
                display_pkg::REG_STATUS:  prdata = {16'd0, frame_count, 8'd0} | 32'(fifo_level);
                display_pkg::REG_PALETTE: prdata = {22'd0, palette_read_color};
                default:                  prdata = 32'd0;
            endcase
        end
    end

endmodule

// File: source/raster_index_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Raster index generator.
// Walks the frame in raster order and offers one palette index per
// pixel, from tile column plus tile row plus a per-frame offset.
// Stops only at a frame boundary.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "display_config.svh"

module raster_index_gen (
    input  logic                        clock_in,
    input  logic                        reset_n_in,
    input  logic                        scan_enable,
    input  logic [3:0]                  index_offset,
    output logic                        gen_valid,
    output display_pkg::index_pixel_t   gen_pixel,
    input  logic                        gen_ready
);

    localparam int X_WIDTH = $clog2(`DISPLAY_FRAME_WIDTH);
    localparam int Y_WIDTH = $clog2(`DISPLAY_FRAME_HEIGHT);
    localparam logic [X_WIDTH-1:0] X_LAST = X_WIDTH'(`DISPLAY_FRAME_WIDTH - 1);
    localparam logic [Y_WIDTH-1:0] Y_LAST = Y_WIDTH'(`DISPLAY_FRAME_HEIGHT - 1);

    display_pkg::scan_state_t state;
    logic [X_WIDTH-1:0]       x;
    logic [Y_WIDTH-1:0]       y;
    logic [3:0]               offset_q;     // Frozen for the whole frame.
    logic [3:0]               tile_col;
    logic [3:0]               tile_row;
    logic                     accepted;

    assign tile_col = 4'(x >> `DISPLAY_TILE_SHIFT);
    assign tile_row = 4'(y >> `DISPLAY_TILE_SHIFT);

    assign gen_valid           = (state == display_pkg::SCAN_ACTIVE);
    assign gen_pixel.index     = tile_col + tile_row + offset_q; // Modulo 16.
    assign gen_pixel.line_end  = (x == X_LAST);
    assign gen_pixel.frame_end = (x == X_LAST) && (y == Y_LAST);

    assign accepted = gen_valid & gen_ready;

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            state    <= display_pkg::SCAN_IDLE;
            x        <= '0;
            y        <= '0;
            offset_q <= 4'd0;
        end else begin
            case (state)
                display_pkg::SCAN_IDLE: begin
                    if (scan_enable) begin
                        state    <= display_pkg::SCAN_ACTIVE;
                        x        <= '0;
                        y        <= '0;
                        offset_q <= index_offset;
                    end
                end
                display_pkg::SCAN_ACTIVE: begin
                    if (accepted) begin
                        if (gen_pixel.frame_end) begin
                            // Frame boundary, the only place to stop.
                            x        <= '0;
                            y        <= '0;
                            offset_q <= index_offset;
                            if (!scan_enable) state <= display_pkg::SCAN_IDLE;
                        end else if (gen_pixel.line_end) begin
                            x <= '0;
                            y <= y + 1'b1;
                        end else begin
                            x <= x + 1'b1;
                        end
                    end
                end
                default: state <= display_pkg::SCAN_IDLE;
            endcase
        end
    end

endmodule

// File: source/pixel_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pixel FIFO.
// Circular buffer of index pixels with valid/ready on both sides.
// Push and pop may happen in the same cycle; level is the occupancy.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "display_config.svh"

module pixel_fifo (
    input  logic                                clock_in,
    input  logic                                reset_n_in,
    input  logic                                push_valid,
    output logic                                push_ready,
    input  display_pkg::index_pixel_t           push_pixel,
    output logic                                pop_valid,
    input  logic                                pop_ready,
    output display_pkg::index_pixel_t           pop_pixel,
    output logic [$clog2(`DISPLAY_FIFO_DEPTH):0] level
);

    localparam int DEPTH     = `DISPLAY_FIFO_DEPTH;
    localparam int PTR_WIDTH = $clog2(DEPTH);

    display_pkg::index_pixel_t mem [DEPTH];
    logic [PTR_WIDTH-1:0]      wr_ptr;
    logic [PTR_WIDTH-1:0]      rd_ptr;
    logic [PTR_WIDTH:0]        count;
    logic                      do_push;
    logic                      do_pop;

    assign push_ready = (count != (PTR_WIDTH + 1)'(DEPTH)); // Low when full.
    assign pop_valid  = (count != '0);
    assign pop_pixel  = mem[rd_ptr];
    assign level      = count;

    assign do_push = push_valid & push_ready;
    assign do_pop  = pop_valid & pop_ready;

    // Storage.
    always_ff @(posedge clock_in) begin
        if (do_push) mem[wr_ptr] <= push_pixel;
    end

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1; // Wraps, depth is a power of two.
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: source/color_palette.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Color palette.
// 16-entry YUV table with reset defaults, a write port and a
// readback port. A registered lookup stage turns index pixels into
// YUV pixels; input is held off during a palette write.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module color_palette (
    input  logic                        clock_in,
    input  logic                        reset_n_in,
    input  logic                        fifo_valid,
    output logic                        fifo_ready,
    input  display_pkg::index_pixel_t   fifo_pixel,
    input  display_pkg::palette_write_t palette_write,
    input  logic [3:0]                  palette_read_index,
    output logic [9:0]                  palette_read_color,
    output logic                        pixel_valid,
    input  logic                        pixel_ready,
    output display_pkg::yuv_pixel_t     pixel_out
);

    logic [9:0] color_table [16];
    logic       take_pixel;

    // Output slot is free, or emptied this cycle, and no write is in flight.
    assign fifo_ready = (!pixel_valid || pixel_ready) && !palette_write.enable;
    assign take_pixel = fifo_valid & fifo_ready;

    assign palette_read_color = color_table[palette_read_index];

    // Table.
    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            for (int i = 0; i < 16; i++) begin
                color_table[i] <= display_pkg::DEFAULT_PALETTE[i];
            end
        end else if (palette_write.enable) begin
            color_table[palette_write.index] <= palette_write.value;
        end
    end

    // Lookup stage, reads the table as it stands before this edge.
    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            pixel_valid         <= 1'b0;
            pixel_out.color     <= display_pkg::YUV_VOID;
            pixel_out.line_end  <= 1'b0;
            pixel_out.frame_end <= 1'b0;
        end else begin
            if (take_pixel) begin
                pixel_valid         <= 1'b1;
                pixel_out.color     <= color_table[fifo_pixel.index];
                pixel_out.line_end  <= fifo_pixel.line_end;
                pixel_out.frame_end <= fifo_pixel.frame_end;
            end else if (pixel_ready) begin
                pixel_valid <= 1'b0; // Taken downstream, nothing new.
            end
        end
    end

endmodule

// File: source/display_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Display pixel path top level.
// APB register block, raster index generator, pixel FIFO and color
// palette feeding a valid/ready YUV pixel stream.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "display_config.svh"

module display_top (
    input  logic                               clock_in,
    input  logic                               reset_n_in,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [`DISPLAY_APB_ADDR_WIDTH-1:0] paddr,
    input  logic [31:0]                        pwdata,
    output logic [31:0]                        prdata,
    output logic                               pready,
    output logic                               pslverr,
    output logic                               pixel_valid,
    input  logic                               pixel_ready,
    output display_pkg::yuv_pixel_t            pixel_out
);

    logic                                 scan_enable;
    logic [3:0]                           index_offset;
    display_pkg::palette_write_t          palette_write;
    logic [3:0]                           palette_read_index;
    logic [9:0]                           palette_read_color;
    logic                                 gen_valid;
    logic                                 gen_ready;
    display_pkg::index_pixel_t            gen_pixel;
    logic                                 fifo_valid;
    logic                                 fifo_ready;
    display_pkg::index_pixel_t            fifo_pixel;
    logic [$clog2(`DISPLAY_FIFO_DEPTH):0] fifo_level;
    logic                                 frame_done;

    assign pslverr    = 1'b0;
    assign frame_done = pixel_valid & pixel_ready & pixel_out.frame_end; // Last pixel out.

    display_apb_regs u_display_apb_regs (
        .clock_in, .reset_n_in, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
        .fifo_level, .frame_done, .scan_enable, .index_offset, .palette_write,
        .palette_read_index, .palette_read_color
    );

    raster_index_gen u_raster_index_gen (
        .clock_in, .reset_n_in, .scan_enable, .index_offset,
        .gen_valid, .gen_pixel, .gen_ready
    );

    pixel_fifo u_pixel_fifo (
        .clock_in, .reset_n_in,
        .push_valid (gen_valid),  .push_ready (gen_ready),  .push_pixel (gen_pixel),
        .pop_valid  (fifo_valid), .pop_ready  (fifo_ready), .pop_pixel  (fifo_pixel),
        .level      (fifo_level)
    );

    color_palette u_color_palette (
        .clock_in, .reset_n_in, .fifo_valid, .fifo_ready, .fifo_pixel, .palette_write,
        .palette_read_index, .palette_read_color, .pixel_valid, .pixel_ready, .pixel_out
    );

endmodule

// File: testbench/display_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Display output checker.
// Follows raster position from accepted output pixels, compares each
// one with a reference model and checks that stalled pixels hold.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "display_config.svh"

module display_checker (
    input  logic                    clock_in,
    input  logic                    reset_n_in,
    input  logic                    pixel_valid,
    input  logic                    pixel_ready,
    input  display_pkg::yuv_pixel_t pixel_out,
    input  logic [3:0]              offset,
    input  logic [15:0][9:0]        palette,
    output int                      error_count,
    output int                      frame_count,
    output int                      pixel_count
);

    localparam int WIDTH  = `DISPLAY_FRAME_WIDTH;
    localparam int HEIGHT = `DISPLAY_FRAME_HEIGHT;

    string                   test_name = "none";
    int                      x;
    int                      y;
    int                      errors;
    int                      frames;
    int                      pixels;
    logic                    held;        // Valid last cycle but not taken.
    display_pkg::yuv_pixel_t held_pixel;
    display_pkg::yuv_pixel_t expected;

    // Expected output for raster position (px, py).
    function automatic display_pkg::yuv_pixel_t reference_pixel(
        input int px, input int py, input logic [3:0] off, input logic [15:0][9:0] pal);
        logic [3:0]              index;
        display_pkg::yuv_pixel_t result;
        index = 4'((px >> `DISPLAY_TILE_SHIFT) + (py >> `DISPLAY_TILE_SHIFT) + int'(off));
        result.color     = pal[index];
        result.line_end  = (px == WIDTH - 1);
        result.frame_end = (px == WIDTH - 1) && (py == HEIGHT - 1);
        return result;
    endfunction

    always @(posedge clock_in) begin
        if (!reset_n_in) begin
            x = 0;
            y = 0;
            errors = 0;
            frames = 0;
            pixels = 0;
            held <= 1'b0;
        end else begin
            if (held && !pixel_valid) begin
                errors++;
                $display("In test %s the output pixel was withdrawn before it was taken",
                         test_name);
            end else if (held && pixel_out !== held_pixel) begin
                errors++;
                $display("ERR %s held pixel x=%0d y=%0d expected %h actual %h",
                         test_name, x, y, held_pixel, pixel_out);
            end
            if (pixel_valid && pixel_ready) begin
                expected = reference_pixel(x, y, offset, palette);
                if (pixel_out !== expected) begin
                    errors++;
                    $display("ERR %s pixel x=%0d y=%0d expected %h actual %h",
                             test_name, x, y, expected, pixel_out);
                end
                pixels++;
                if (x == WIDTH - 1) begin
                    x = 0;
                    if (y == HEIGHT - 1) begin
                        y = 0;
                        frames++;
                    end else begin
                        y++;
                    end
                end else begin
                    x++;
                end
            end
            held       <= pixel_valid && !pixel_ready;
            held_pixel <= pixel_out;
        end
        error_count <= errors;
        frame_count <= frames;
        pixel_count <= pixels;
    end

endmodule

// File: testbench/tb_display_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Display pixel path testbench.
// Drives APB register traffic and scan frames through the DUT, keeps
// a shadow palette for the checker and reports the error counts.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "display_config.svh"

module tb_display_top;

    localparam int APB_TIMEOUT   = 16;
    localparam int FRAME_TIMEOUT = 4000;
    localparam int FRAME_PIXELS  = `DISPLAY_FRAME_WIDTH * `DISPLAY_FRAME_HEIGHT;

    logic                               clock_in;
    logic                               reset_n_in;
    logic                               psel;
    logic                               penable;
    logic                               pwrite;
    logic [`DISPLAY_APB_ADDR_WIDTH-1:0] paddr;
    logic [31:0]                        pwdata;
    logic [31:0]                        prdata;
    logic                               pready;
    logic                               pslverr;
    logic                               pixel_valid;
    logic                               pixel_ready;
    display_pkg::yuv_pixel_t            pixel_out;
    logic [3:0]                         shadow_offset;
    logic [15:0][9:0]                   shadow_palette;
    logic [15:0]                        lfsr_state;
    logic                               random_ready;   // LFSR drives pixel_ready.
    logic [31:0]                        read_data;
    logic [9:0]                         color;
    logic [3:0]                         index;
    int                                 reg_errors;
    int                                 timeout_count;
    int                                 frames_expected;
    int                                 pixel_errors;
    int                                 frames_seen;
    int                                 pixels_seen;

    display_top u_display_top (
        .clock_in, .reset_n_in, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
        .pready, .pslverr, .pixel_valid, .pixel_ready, .pixel_out
    );

    display_checker u_display_checker (
        .clock_in, .reset_n_in, .pixel_valid, .pixel_ready, .pixel_out,
        .offset (shadow_offset), .palette (shadow_palette), .error_count (pixel_errors),
        .frame_count (frames_seen), .pixel_count (pixels_seen)
    );

    initial begin
        clock_in = 1'b0;
        forever #5 clock_in = ~clock_in;
    end

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    function logic [15:0] random_bits(input int count);
        logic [15:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value      = {value[14:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return value;
    endfunction

    always @(posedge clock_in) begin
        #1;
        pixel_ready = random_ready ? (random_bits(1) != 16'd0) : 1'b1;
    end

    task automatic finish_run();
        $display("Closing counts: %0d pixel errors, %0d register errors, %0d timeouts",
                 pixel_errors, reg_errors, timeout_count);
        if (pixel_errors + reg_errors + timeout_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    task automatic start_test(input string name);
        u_display_checker.test_name = name;
        $display("Test %s", name);
    endtask

    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata);
        int   waits;
        logic done;
        waits = 0;
        @(posedge clock_in);
        #1;
        psel    = 1'b1;         // Setup phase.
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clock_in);
        #1;
        penable = 1'b1;
        @(posedge clock_in);
        while (!pready && waits < APB_TIMEOUT) begin
            waits++;
            @(posedge clock_in);
        end
        done  = pready;
        rdata = prdata;
        if (done) begin
            check_reg($sformatf("pslverr at %h", addr), 32'd0, 32'(pslverr));
        end
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        if (!done) begin
            timeout_count++;
            $display("APB transfer to address %h never saw pready", addr);
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_transfer(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        apb_transfer(1'b0, addr, 32'd0, data);
    endtask

    task automatic check_reg(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (actual !== expected) begin
            reg_errors++;
            $display("ERR %s %s expected %h actual %h",
                     u_display_checker.test_name, what, expected, actual);
        end
    endtask

    task automatic check_palette();
        logic [31:0] data;
        for (int i = 0; i < 16; i++) begin
            apb_read(8'(`DISPLAY_REG_PALETTE_BASE + 4 * i), data);
            check_reg($sformatf("palette[%0d]", i), {22'd0, shadow_palette[i]}, data);
        end
    endtask

    task automatic wait_frames(input int target);
        int cycles;
        cycles = 0;
        while (frames_seen < target && cycles < FRAME_TIMEOUT) begin
            @(posedge clock_in);
            cycles++;
        end
        if (frames_seen < target) begin
            timeout_count++;
            $display("Timed out waiting for the end of frame %0d in test %s",
                     target, u_display_checker.test_name);
        end
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (pixel_valid && cycles < FRAME_TIMEOUT) begin
            @(posedge clock_in);
            cycles++;
        end
        if (pixel_valid) begin
            timeout_count++;
            $display("Output never drained in test %s", u_display_checker.test_name);
        end
    endtask

    // Enable the scan, then clear enable so it stops after the last frame.
    task automatic scan_frames(input int count, input logic [3:0] offset);
        logic [31:0] ctrl;
        int          first;
        first         = frames_seen;
        shadow_offset = offset;
        apb_write(`DISPLAY_REG_CTRL, {24'd0, offset, 4'b0001});
        apb_read(`DISPLAY_REG_CTRL, ctrl);
        check_reg("CTRL", {24'd0, offset, 4'b0001}, ctrl);
        for (int f = 0; f < count; f++) begin
            if (f == count - 1) apb_write(`DISPLAY_REG_CTRL, {24'd0, offset, 4'b0000});
            wait_frames(first + f + 1);
        end
        frames_expected += count;
        wait_drained();
    endtask

    initial begin
        reset_n_in      = 1'b0;
        psel            = 1'b0;
        penable         = 1'b0;
        pwrite          = 1'b0;
        paddr           = '0;
        pwdata          = 32'd0;
        pixel_ready     = 1'b1;
        random_ready    = 1'b0;
        lfsr_state      = 16'd99;
        shadow_offset   = 4'd0;
        shadow_palette  = display_pkg::DEFAULT_PALETTE;
        reg_errors      = 0;
        timeout_count   = 0;
        frames_expected = 0;
        repeat (16) @(posedge clock_in);
        #1 reset_n_in = 1'b1;

        start_test("default_palette");
        check_palette();
        scan_frames(1, 4'd0);

        start_test("palette_write");
        for (int i = 0; i < 6; i++) begin
            index = 4'(random_bits(4));
            color = 10'(random_bits(10));
            apb_write(8'(`DISPLAY_REG_PALETTE_BASE + 4 * index), {22'd0, color});
            shadow_palette[index] = color;
        end
        check_palette();
        scan_frames(1, 4'd0);

        start_test("offset");
        scan_frames(1, 4'd5);

        start_test("back_pressure");
        random_ready = 1'b1;
        scan_frames(1, 4'd3);
        random_ready = 1'b0;

        start_test("status");
        scan_frames(2, 4'd9);
        apb_read(`DISPLAY_REG_STATUS, read_data);
        check_reg("STATUS", {16'd0, 8'(frames_expected), 8'd0}, read_data);
        check_reg("pixel count", 32'(frames_expected * FRAME_PIXELS), 32'(pixels_seen));
        finish_run();
    end

endmodule

// File: tb.f
+incdir+source
source/display_pkg.sv
source/display_apb_regs.sv
source/raster_index_gen.sv
source/pixel_fifo.sv
source/color_palette.sv
source/display_top.sv
testbench/display_checker.sv
testbench/tb_display_top.sv
